// File: include/riscv_cfg.svh
`ifndef RISCV_CFG_SVH
`define RISCV_CFG_SVH

// Datapath and bus widths
`define XLEN 32
`define ADDR_W 12
`define REG_W 5

// First fetch address
`define RESET_PC 0

`endif

// File: hw/riscvIsaPkg.sv
`default_nettype none
`include "riscv_cfg.svh"

package riscvIsaPkg;

	typedef logic [`XLEN-1:0] wordT;
	typedef logic [`ADDR_W-1:0] addrT;    // Byte address
	typedef logic [`REG_W-1:0] regIdxT;
	typedef logic [2:0] funct3T;

	// Major opcodes of RV32I
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		BRANCH = 7'b1100011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		SYSTEM = 7'b1110011
	} opcodeE;

endpackage

`default_nettype wire

// File: hw/riscvCtrlPkg.sv
`default_nettype none
`include "riscv_cfg.svh"

package riscvCtrlPkg;
	import riscvIsaPkg::*;

	typedef enum logic [3:0] {
		ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASSB
	} aluOpE;

	typedef enum logic [1:0] {A_REG, A_PC, A_ZERO} aSelE;
	typedef enum logic {B_REG, B_IMM} bSelE;
	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wbSelE;
	typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JAL, PC_JALR} pcSelE;

	typedef struct packed {
		aluOpE aluOp;
		aSelE aSel;
		bSelE bSel;
		wbSelE wbSel;
		logic regWrite;
		logic memRead;
		logic memWrite;
		funct3T funct3;    // Access size or branch kind
		pcSelE pcSel;
		logic haltReq;
	} ctrlT;

	typedef struct packed {
		logic csn;    // Active low
		logic we;
		logic [3:0] be;
		logic [`ADDR_W-3:0] addr;    // Word address
		wordT wdata;
	} dMemReqT;

	typedef struct packed {
		logic we;
		regIdxT idx;
		wordT data;
	} rfWriteT;

endpackage

`default_nettype wire

// File: hw/riscvDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module riscvDecoder (
	input wire riscvIsaPkg::wordT instr,
	output riscvCtrlPkg::ctrlT ctrl,
	output riscvIsaPkg::wordT imm
	);

	import riscvIsaPkg::*;
	import riscvCtrlPkg::*;

	opcodeE opcode;
	funct3T f3;
	logic alt;    // instr[30], selects SUB and SRA

	assign opcode = opcodeE'(instr[6:0]);
	assign f3 = instr[14:12];
	assign alt = instr[30];

	function automatic aluOpE aluFromFunct(input funct3T f, input logic sub, input logic arith);
		case (f)
			3'b000: aluFromFunct = sub ? SUB : ADD;
			3'b001: aluFromFunct = SLL;
			3'b010: aluFromFunct = SLT;
			3'b011: aluFromFunct = SLTU;
			3'b100: aluFromFunct = XOR;
			3'b101: aluFromFunct = arith ? SRA : SRL;
			3'b110: aluFromFunct = OR;
			default: aluFromFunct = AND;
		endcase
	endfunction

	always_comb begin
		ctrl = '{aluOp: ADD, aSel: A_REG, bSel: B_IMM, wbSel: WB_ALU, regWrite: 1'b0,
			memRead: 1'b0, memWrite: 1'b0, funct3: f3, pcSel: PC_SEQ, haltReq: 1'b0};
		case (opcode)
			OP: begin
				ctrl.bSel = B_REG;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = aluFromFunct(f3, alt, alt);
			end
			OP_IMM: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = aluFromFunct(f3, 1'b0, alt);    // No SUBI
			end
			LUI: begin
				ctrl.aSel = A_ZERO;
				ctrl.aluOp = PASSB;
				ctrl.regWrite = 1'b1;
			end
			AUIPC: begin
				ctrl.aSel = A_PC;
				ctrl.regWrite = 1'b1;
			end
			JAL: begin
				ctrl.wbSel = WB_PC4;
				ctrl.regWrite = 1'b1;
				ctrl.pcSel = PC_JAL;
			end
			JALR: begin
				ctrl.wbSel = WB_PC4;
				ctrl.regWrite = 1'b1;
				ctrl.pcSel = PC_JALR;    // Target from ALU sum
			end
			BRANCH: begin
				ctrl.bSel = B_REG;
				ctrl.pcSel = PC_BRANCH;
			end
			LOAD: begin
				ctrl.memRead = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = WB_MEM;
			end
			STORE: ctrl.memWrite = 1'b1;
			SYSTEM: ctrl.haltReq = (instr[31:7] == 25'h0002000);    // EBREAK
			default: ;
		endcase
	end

	// Immediate by format
	always_comb begin
		case (opcode)
			STORE: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			BRANCH: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
			LUI, AUIPC: imm = {instr[31:12], 12'b0};
			JAL: imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
			default: imm = {{20{instr[31]}}, instr[31:20]};
		endcase
	end

endmodule

`default_nettype wire

// File: hw/riscvAlu.sv
`timescale 1ns/100ps
`default_nettype none

module riscvAlu (
	input wire riscvIsaPkg::wordT a,
	input wire riscvIsaPkg::wordT b,
	input wire riscvCtrlPkg::aluOpE op,
	input wire riscvIsaPkg::funct3T funct3,
	output riscvIsaPkg::wordT y,
	output logic taken
	);

	import riscvCtrlPkg::*;

	logic [4:0] shamt;
	logic lessS, lessU;

	assign shamt = b[4:0];
	assign lessS = $signed(a) < $signed(b);
	assign lessU = a < b;

	always_comb begin
		case (op)
			ADD: y = a + b;
			SUB: y = a - b;
			SLL: y = a << shamt;
			SLT: y = {31'b0, lessS};
			SLTU: y = {31'b0, lessU};
			XOR: y = a ^ b;
			SRL: y = a >> shamt;
			SRA: y = $signed(a) >>> shamt;
			OR: y = a | b;
			AND: y = a & b;
			PASSB: y = b;
			default: y = '0;
		endcase
	end

	// Branch condition
	always_comb begin
		case (funct3)
			3'b000: taken = a == b;
			3'b001: taken = a != b;
			3'b100: taken = lessS;
			3'b101: taken = !lessS;
			3'b110: taken = lessU;
			3'b111: taken = !lessU;
			default: taken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/riscvFetch.sv
`timescale 1ns/100ps
`default_nettype none
`include "riscv_cfg.svh"

module riscvFetch (
	input wire CLK,
	input wire RSTn,
	input wire riscvCtrlPkg::pcSelE pcSel,
	input wire taken,
	input wire haltReq,
	input wire riscvIsaPkg::wordT imm,
	input wire riscvIsaPkg::wordT jalrTarget,
	output riscvIsaPkg::addrT pc,
	output riscvIsaPkg::addrT pcPlus4,
	output logic halt,
	output riscvIsaPkg::wordT numInst
	);

	import riscvIsaPkg::*;
	import riscvCtrlPkg::*;

	addrT pcTarget;
	addrT nextPc;

	assign pcPlus4 = pc + addrT'(4);
	assign pcTarget = pc + imm[`ADDR_W-1:0];

	always_comb begin
		case (pcSel)
			PC_BRANCH: nextPc = taken ? pcTarget : pcPlus4;
			PC_JAL: nextPc = pcTarget;
			PC_JALR: nextPc = {jalrTarget[`ADDR_W-1:1], 1'b0};
			default: nextPc = pcPlus4;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			pc <= addrT'(`RESET_PC);
			halt <= 1'b0;
			numInst <= '0;
		end else if (!halt) begin
			numInst <= numInst + 1'b1;    // EBREAK counts too
			if (haltReq)
				halt <= 1'b1;
			else
				pc <= nextPc;
		end
	end

endmodule

`default_nettype wire

// File: hw/riscvLsu.sv
`timescale 1ns/100ps
`default_nettype none
`include "riscv_cfg.svh"

module riscvLsu (
	input wire riscvIsaPkg::wordT addr,
	input wire riscvIsaPkg::wordT storeData,
	input wire riscvIsaPkg::funct3T funct3,
	input wire memRead,
	input wire memWrite,
	input wire active,
	output riscvCtrlPkg::dMemReqT dMemReq,
	input wire riscvIsaPkg::wordT dMemData,
	output riscvIsaPkg::wordT loadData
	);

	import riscvIsaPkg::*;

	logic [1:0] offset;
	wordT lane;    // Addressed bytes moved to bit 0

	assign offset = addr[1:0];
	assign lane = dMemData >> {offset, 3'b000};

	always_comb begin
		dMemReq.csn = !(active && (memRead || memWrite));
		dMemReq.we = active && memWrite;
		dMemReq.addr = addr[`ADDR_W-1:2];
		case (funct3[1:0])
			2'b00: begin
				dMemReq.wdata = {4{storeData[7:0]}};
				dMemReq.be = 4'b0001 << offset;
			end
			2'b01: begin
				dMemReq.wdata = {2{storeData[15:0]}};
				dMemReq.be = offset[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				dMemReq.wdata = storeData;
				dMemReq.be = 4'b1111;
			end
		endcase
	end

	always_comb begin
		case (funct3)
			3'b000: loadData = {{24{lane[7]}}, lane[7:0]};
			3'b001: loadData = {{16{lane[15]}}, lane[15:0]};
			3'b100: loadData = {24'b0, lane[7:0]};
			3'b101: loadData = {16'b0, lane[15:0]};
			default: loadData = dMemData;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/riscvTop.sv
`timescale 1ns/100ps
`default_nettype none

module riscvTop (
	input wire CLK,
	input wire RSTn,

	output logic iMemCsn,
	output riscvIsaPkg::addrT iMemAddr,
	input wire riscvIsaPkg::wordT iMemData,

	output riscvIsaPkg::regIdxT rfRa1,
	output riscvIsaPkg::regIdxT rfRa2,
	input wire riscvIsaPkg::wordT rfRd1,
	input wire riscvIsaPkg::wordT rfRd2,
	output riscvCtrlPkg::rfWriteT rfWr,

	output riscvCtrlPkg::dMemReqT dMemReq,
	input wire riscvIsaPkg::wordT dMemData,

	output logic halt,
	output riscvIsaPkg::wordT numInst
	);

	import riscvIsaPkg::*;
	import riscvCtrlPkg::*;

	ctrlT ctrl;
	wordT imm;
	wordT opA, opB;
	wordT aluY;
	wordT loadData;
	logic taken;
	logic active;    // Out of reset and running
	addrT pc, pcPlus4;

	assign active = !RSTn && !halt;
	assign iMemCsn = !active;
	assign iMemAddr = pc;
	assign rfRa1 = iMemData[19:15];
	assign rfRa2 = iMemData[24:20];

	riscvDecoder uDecoder (.instr(iMemData), .ctrl(ctrl), .imm(imm));

	always_comb begin
		case (ctrl.aSel)
			A_PC: opA = wordT'(pc);
			A_ZERO: opA = '0;
			default: opA = rfRd1;
		endcase
		opB = (ctrl.bSel == B_IMM) ? imm : rfRd2;
	end

	riscvAlu uAlu (.a(opA), .b(opB), .op(ctrl.aluOp), .funct3(ctrl.funct3), .y(aluY),
		.taken(taken));

	riscvFetch uFetch (
		.CLK(CLK),
		.RSTn(RSTn),
		.pcSel(ctrl.pcSel),
		.taken(taken),
		.haltReq(ctrl.haltReq),
		.imm(imm),
		.jalrTarget(aluY),
		.pc(pc),
		.pcPlus4(pcPlus4),
		.halt(halt),
		.numInst(numInst)
	);

	riscvLsu uLsu (
		.addr(aluY),
		.storeData(rfRd2),
		.funct3(ctrl.funct3),
		.memRead(ctrl.memRead),
		.memWrite(ctrl.memWrite),
		.active(active),
		.dMemReq(dMemReq),
		.dMemData(dMemData),
		.loadData(loadData)
	);

	// Writeback
	always_comb begin
		rfWr.we = ctrl.regWrite && active;
		rfWr.idx = iMemData[11:7];
		case (ctrl.wbSel)
			WB_MEM: rfWr.data = loadData;
			WB_PC4: rfWr.data = wordT'(pcPlus4);
			default: rfWr.data = aluY;
		endcase
	end

endmodule

`default_nettype wire

// File: test/tbRiscvModels.sv
`timescale 1ns/100ps
`default_nettype none
`include "riscv_cfg.svh"

// Instruction memory, data memory and register file around the core
module platformModels (
	input wire CLK,
	input wire iMemCsn,
	input wire riscvIsaPkg::addrT iMemAddr,
	output riscvIsaPkg::wordT iMemData,
	input wire riscvIsaPkg::regIdxT rfRa1,
	input wire riscvIsaPkg::regIdxT rfRa2,
	output riscvIsaPkg::wordT rfRd1,
	output riscvIsaPkg::wordT rfRd2,
	input wire riscvCtrlPkg::rfWriteT rfWr,
	input wire riscvCtrlPkg::dMemReqT dMemReq,
	output riscvIsaPkg::wordT dMemData
	);

	import riscvIsaPkg::*;

	wordT iMem [0:(1 << (`ADDR_W - 2)) - 1];
	wordT dMem [0:(1 << (`ADDR_W - 2)) - 1];
	wordT regs [0:31];
	wordT byteMask;
	int writeCount = 0;    // Register and memory writes seen

	assign iMemData = iMemCsn ? '0 : iMem[iMemAddr[`ADDR_W-1:2]];
	assign dMemData = dMemReq.csn ? 'x : dMem[dMemReq.addr];    // Valid only while selected
	assign rfRd1 = (rfRa1 == 0) ? '0 : regs[rfRa1];    // x0 reads zero
	assign rfRd2 = (rfRa2 == 0) ? '0 : regs[rfRa2];
	assign byteMask = {{8{dMemReq.be[3]}}, {8{dMemReq.be[2]}}, {8{dMemReq.be[1]}},
		{8{dMemReq.be[0]}}};

	always @(posedge CLK) begin
		if (rfWr.we) begin
			writeCount <= writeCount + 1;
			if (rfWr.idx != 0)
				regs[rfWr.idx] <= rfWr.data;
		end
		if (!dMemReq.csn && dMemReq.we) begin
			writeCount <= writeCount + 1;
			dMem[dMemReq.addr] <= (dMem[dMemReq.addr] & ~byteMask) | (dMemReq.wdata & byteMask);
		end
	end

endmodule

`default_nettype wire

// File: test/riscvTopTb.sv
`timescale 1ns/100ps
`default_nettype none

module riscvTopTb;

	import riscvIsaPkg::*;
	import riscvCtrlPkg::*;

	localparam wordT EBREAK = 32'h0010_0073;

	logic CLK;
	logic RSTn;
	logic iMemCsn;
	addrT iMemAddr;
	wordT iMemData;
	regIdxT rfRa1, rfRa2;
	wordT rfRd1, rfRd2;
	rfWriteT rfWr;
	dMemReqT dMemReq;
	wordT dMemData;
	logic halt;
	wordT numInst;

	integer seed = 32'h45a4_bc9c;
	int errors = 0;
	int checks = 0;
	int progLen;
	logic [7:0] shadow [0:31];    // Bytes 0x100..0x11f as stores should leave them
	wordT expReg [0:31];

	riscvTop DUT (.*);
	platformModels models (.*);

	initial CLK = 1'b0;
	always #10 CLK = ~CLK;

	task automatic checkValue(input wordT got, input wordT exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// Instruction encoders
	function automatic wordT encR(input int f7, input int rs2, input int rs1, input int f3,
		input int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic wordT encI(input int imm, input int rs1, input int f3, input int rd,
		input logic [6:0] opc);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
	endfunction

	function automatic wordT encS(input int imm, input int rs2, input int rs1, input int f3);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
	endfunction

	function automatic wordT encB(input int imm, input int rs2, input int rs1, input int f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic wordT encJ(input int imm, input int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
	endfunction

	// Reference results from the RV32I definitions
	function automatic wordT refAlu(input int f3, input logic alt, input wordT a, input wordT b);
		case (f3)
			0: return alt ? a - b : a + b;
			1: return a << b[4:0];
			2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3: return (a < b) ? 32'd1 : 32'd0;
			4: return a ^ b;
			5: return alt ? wordT'($signed(a) >>> b[4:0]) : a >> b[4:0];
			6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic refBranch(input int f3, input wordT a, input wordT b);
		case (f3)
			0: return a == b;
			1: return a != b;
			4: return $signed(a) < $signed(b);
			5: return $signed(a) >= $signed(b);
			6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	function automatic wordT fillWord(input int i);
		return (i + 1) * 32'h9E37_79B9;
	endfunction

	function automatic wordT loadRef(input int off, input int f3);
		wordT w;
		w = {shadow[off + 3], shadow[off + 2], shadow[off + 1], shadow[off]};
		case (f3)
			0: return {{24{w[7]}}, w[7:0]};
			1: return {{16{w[15]}}, w[15:0]};
			4: return {24'b0, w[7:0]};
			5: return {16'b0, w[15:0]};
			default: return w;
		endcase
	endfunction

	task automatic clearModels();
		for (int i = 0; i < 1024; i++) begin
			models.iMem[i] <= '0;
			models.dMem[i] <= fillWord(i);
		end
		for (int r = 0; r < 32; r++) begin
			models.regs[r] <= '0;
			expReg[r] = '0;
		end
		progLen = 0;
	endtask

	task automatic emit(input wordT ins);
		models.iMem[progLen] <= ins;
		progLen++;
	endtask

	task automatic storeRef(input int off, input int nBytes, input wordT data);
		for (int b = 0; b < nBytes; b++)
			shadow[off + b] = data[8 * b +: 8];
	endtask

	task automatic emitLoad(input int off, input int f3, input int rd);
		emit(encI(off, 1, f3, rd, 7'h03));
		expReg[rd] = loadRef(off, f3);
	endtask

	// Reset, run to EBREAK, then watch the halted core
	task automatic runProgram(input int expCount);
		int cycles;
		int writesAtHalt;
		@(posedge CLK);
		RSTn <= 1'b1;
		repeat (16) @(posedge CLK);
		RSTn <= 1'b0;
		cycles = 0;
		@(negedge CLK);
		while (!halt && cycles < 500) begin
			@(negedge CLK);
			cycles++;
		end
		if (!halt) begin
			errors++;
			$display("Halt never came within %0d cycles, at time %0t", cycles, $time);
		end
		checkValue(numInst, expCount, "numInst at halt");
		checkValue(iMemCsn, 1'b1, "iMemCsn after halt");
		checkValue(dMemReq.csn, 1'b1, "data chip select after halt");
		writesAtHalt = models.writeCount;
		for (int i = 0; i < 20; i++) begin
			@(negedge CLK);
			checkValue(numInst, expCount, "numInst while halted");
		end
		checkValue(models.writeCount, writesAtHalt, "writes while halted");
	endtask

	task automatic testAlu();
		wordT a, b, sh, r;
		wordT imms [0:7];
		clearModels();
		a = $random(seed);
		b = $random(seed);
		sh = 32'd37 | ($random(seed) & 32'hFFFF_FFC0);    // Amount above 31
		models.regs[1] <= a;
		models.regs[2] <= b;
		models.regs[4] <= sh;
		for (int f = 0; f < 8; f++)
			emit(encR(0, 2, 1, f, 8 + f));
		emit(encR(32, 2, 1, 0, 16));
		emit(encR(32, 4, 1, 5, 17));
		emit(encR(0, 4, 1, 5, 18));
		emit(encR(0, 4, 1, 1, 19));
		for (int f = 0; f < 8; f++) begin
			r = $random(seed);
			imms[f] = (f == 1 || f == 5) ? (r & 32'd31) : {{20{r[11]}}, r[11:0]};
			emit(encI(imms[f], 1, f, 20 + f, 7'h13));
		end
		emit(encI(32'h400 | 13, 1, 5, 28, 7'h13));    // SRAI
		emit(EBREAK);
		runProgram(22);
		for (int f = 0; f < 8; f++) begin
			checkValue(models.regs[8 + f], refAlu(f, 1'b0, a, b), $sformatf("R-type funct3 %0d", f));
			checkValue(models.regs[20 + f], refAlu(f, 1'b0, a, imms[f]),
				$sformatf("I-type funct3 %0d", f));
		end
		checkValue(models.regs[16], refAlu(0, 1'b1, a, b), "SUB");
		checkValue(models.regs[17], refAlu(5, 1'b1, a, sh), "SRA");
		checkValue(models.regs[18], refAlu(5, 1'b0, a, sh), "SRL");
		checkValue(models.regs[19], refAlu(1, 1'b0, a, sh), "SLL");
		checkValue(models.regs[28], refAlu(5, 1'b1, a, 13), "SRAI");
	endtask

	task automatic testUpper();
		wordT u;
		clearModels();
		u = $random(seed) & 32'h000F_FFFF;
		emit({20'hABCDE, 5'd5, 7'b0110111});
		emit(encI(0, 0, 0, 0, 7'h13));
		emit({u[19:0], 5'd6, 7'b0010111});    // AUIPC at PC 8
		emit(EBREAK);
		runProgram(4);
		checkValue(models.regs[5], 32'hABCD_E000, "LUI");
		checkValue(models.regs[6], (u << 12) + 32'd8, "AUIPC");
	endtask

	task automatic testMemory();
		wordT data, w;
		clearModels();
		data = $random(seed) | 32'h0000_8080;    // Negative byte and half
		for (int k = 0; k < 32; k++) begin
			w = fillWord(64 + k / 4);
			shadow[k] = w[8 * (k % 4) +: 8];
		end
		models.regs[1] <= 32'h100;
		models.regs[2] <= data;
		for (int i = 0; i < 4; i++) begin
			emit(encS(5 * i, 2, 1, 0));    // One byte in each lane
			storeRef(5 * i, 1, data);
		end
		emit(encS(16, 2, 1, 1));
		storeRef(16, 2, data);
		emit(encS(22, 2, 1, 1));
		storeRef(22, 2, data);
		emit(encS(24, 2, 1, 2));
		storeRef(24, 4, data);
		emitLoad(5, 0, 10);
		emitLoad(5, 4, 11);
		emitLoad(22, 1, 12);
		emitLoad(22, 5, 13);
		emitLoad(24, 2, 14);
		emitLoad(2, 0, 15);
		emitLoad(15, 4, 16);
		emitLoad(18, 5, 17);
		emit(EBREAK);
		runProgram(16);
		for (int k = 0; k < 8; k++)
			checkValue(models.dMem[64 + k], {shadow[4 * k + 3], shadow[4 * k + 2],
				shadow[4 * k + 1], shadow[4 * k]}, $sformatf("data word %0d", 64 + k));
		checkValue(models.dMem[63], fillWord(63), "word below stores");
		checkValue(models.dMem[72], fillWord(72), "word above stores");
		for (int rd = 10; rd < 18; rd++)
			checkValue(models.regs[rd], expReg[rd], $sformatf("load into x%0d", rd));
	endtask

	task automatic testBranches();
		wordT src [0:3];
		int f3, rs1, rs2, rd, count;
		logic tk;
		clearModels();
		src[1] = 32'hFFFF_FFFB;
		src[2] = 32'd3;
		src[3] = 32'hFFFF_FFFB;
		for (int r = 1; r < 4; r++)
			models.regs[r] <= src[r];
		count = 1;
		for (int k = 0; k < 6; k++) begin
			f3 = (k < 2) ? k : k + 2;
			for (int p = 0; p < 3; p++) begin
				rs1 = (p == 2) ? 2 : 1;
				rs2 = (p == 0) ? 3 : ((p == 1) ? 2 : 1);
				rd = 10 + 3 * k + p;
				tk = refBranch(f3, src[rs1], src[rs2]);
				emit(encB(8, rs2, rs1, f3));
				emit(encI(1, 0, 0, rd, 7'h13));    // Marker, skipped when taken
				expReg[rd] = tk ? 32'd0 : 32'd1;
				count += tk ? 1 : 2;
			end
		end
		emit(EBREAK);
		runProgram(count);
		for (int r = 10; r < 28; r++)
			checkValue(models.regs[r], expReg[r], $sformatf("branch marker x%0d", r));
	endtask

	task automatic testJumps();
		clearModels();
		emit(encJ(8, 5));
		emit(encI(1, 0, 0, 6, 7'h13));
		emit(encI(28, 0, 0, 7, 7'h13));
		emit(encI(-3, 7, 0, 8, 7'h67));    // Target 25, runs at 24
		emit(encI(2, 0, 0, 6, 7'h13));
		emit(encI(3, 0, 0, 6, 7'h13));
		emit({20'h0, 5'd9, 7'b0010111});    // AUIPC records the PC it runs at
		emit(EBREAK);
		runProgram(5);
		checkValue(models.regs[5], 32'd4, "JAL link");
		checkValue(models.regs[8], 32'd16, "JALR link");
		checkValue(models.regs[7], 32'd28, "instruction at JAL target");
		checkValue(models.regs[9], 32'd24, "PC at JALR target");
		checkValue(models.regs[6], 32'd0, "skipped instructions");
	endtask

	initial begin
		RSTn = 1'b1;
		testAlu();
		testUpper();
		testMemory();
		testBranches();
		testJumps();
		$display("Errors: %0d of %0d checks", errors, checks);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+include
hw/riscvIsaPkg.sv
hw/riscvCtrlPkg.sv
hw/riscvDecoder.sv
hw/riscvAlu.sv
hw/riscvFetch.sv
hw/riscvLsu.sv
hw/riscvTop.sv
test/tbRiscvModels.sv
test/riscvTopTb.sv
